//--- common/isa_pkg.sv
/*
 * Instruction set definitions shared by the core stages.
 * Holds field widths, opcodes, ALU operation codes and the
 * instruction word union that every stage decodes through.
 */
package isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPC_W      = 5;
    localparam int IMM_W      = 17;
    localparam int TGT_W      = 27;

    // major opcodes
    localparam logic [OPC_W-1:0] OPC_RTYPE = 5'b00000;
    localparam logic [OPC_W-1:0] OPC_J     = 5'b00001;
    localparam logic [OPC_W-1:0] OPC_BNE   = 5'b00010;
    localparam logic [OPC_W-1:0] OPC_ADDI  = 5'b00101;
    localparam logic [OPC_W-1:0] OPC_BLT   = 5'b00110;
    localparam logic [OPC_W-1:0] OPC_SW    = 5'b00111;
    localparam logic [OPC_W-1:0] OPC_LW    = 5'b01000;

    // R-type function field
    localparam logic [4:0] ALU_ADD = 5'b00000;
    localparam logic [4:0] ALU_SUB = 5'b00001;
    localparam logic [4:0] ALU_AND = 5'b00010;
    localparam logic [4:0] ALU_OR  = 5'b00011;
    localparam logic [4:0] ALU_SLL = 5'b00100;
    localparam logic [4:0] ALU_SRA = 5'b00101;

    typedef struct packed {
        logic [OPC_W-1:0]      opcode;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [4:0]            shamt;
        logic [4:0]            aluop;
        logic [1:0]            zero;   // always 0
    } r_fmt_t;

    typedef struct packed {
        logic [OPC_W-1:0]      opcode;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs;
        logic [IMM_W-1:0]      imm;    // signed offset
    } i_fmt_t;

    typedef struct packed {
        logic [OPC_W-1:0] opcode;
        logic [TGT_W-1:0] target;      // absolute word address
    } j_fmt_t;

    // one instruction word, three views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } instr_t;

endpackage

//--- common/pipe_pkg.sv
/*
 * Pipeline-level constants used by the core stages:
 * reset PC, the bubble word, the hardwired zero register
 * and the operand forwarding select codes.
 */
package pipe_pkg;

    localparam logic [31:0] RESET_PC = 32'd0;
    localparam logic [31:0] NOP_WORD = 32'd0;   // add r0,r0,r0
    localparam logic [4:0]  REG_ZERO = 5'd0;

    // execute operand sources
    localparam logic [1:0] FWD_REG = 2'd0;      // value read in decode
    localparam logic [1:0] FWD_MEM = 2'd1;      // execute/memory result
    localparam logic [1:0] FWD_WB  = 2'd2;      // writeback data

endpackage

//--- execute/alu.sv
/*
 * Combinational ALU for the execute stage. Also provides the
 * equality and signed less-than flags used by bne and blt.
 */
`timescale 1ns/1ps

module alu
    import isa_pkg::*;
(
    input  logic [XLEN-1:0] op_a_i,
    input  logic [XLEN-1:0] op_b_i,
    input  logic [4:0]      aluop_i,
    input  logic [4:0]      shamt_i,
    output logic [XLEN-1:0] result_o,
    output logic            not_equal_o,
    output logic            less_than_o
);

    always_comb begin
        case (aluop_i)
            ALU_ADD: result_o = op_a_i + op_b_i;
            ALU_SUB: result_o = op_a_i - op_b_i;
            ALU_AND: result_o = op_a_i & op_b_i;
            ALU_OR:  result_o = op_a_i | op_b_i;
            ALU_SLL: result_o = op_a_i << shamt_i;
            ALU_SRA: result_o = $signed(op_a_i) >>> shamt_i;
            default: result_o = '0;
        endcase
    end

    assign not_equal_o = (op_a_i != op_b_i);
    assign less_than_o = ($signed(op_a_i) < $signed(op_b_i));   // overflow ignored

endmodule

//--- execute/execute_stage.sv
/*
 * Execute stage: operand forwarding from memory and writeback,
 * branch and jump resolution, and the execute/memory register.
 * Branches compare $rd against $rs through the ALU compare outputs.
 */
`timescale 1ns/1ps

module execute_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                  clock_i,
    input  logic                  rst_n_i,
    input  logic [XLEN-1:0]       dx_pc_i,
    input  instr_t                dx_ir_i,
    input  logic [XLEN-1:0]       dx_a_i,
    input  logic [XLEN-1:0]       dx_b_i,
    input  logic                  wb_we_i,
    input  logic [REG_ADDR_W-1:0] wb_rd_i,
    input  logic [XLEN-1:0]       wb_data_i,
    output logic                  redirect_o,
    output logic [XLEN-1:0]       redirect_pc_o,
    output instr_t                xm_ir_o,
    output logic [XLEN-1:0]       xm_result_o,
    output logic [XLEN-1:0]       xm_store_o
);

    logic [OPC_W-1:0]      opcode;
    logic [REG_ADDR_W-1:0] src_a, src_b, m_rd;
    logic [1:0]            fwd_a, fwd_b;
    logic [XLEN-1:0]       reg_a, reg_b, op_a, op_b, imm_sext, alu_result;
    logic [4:0]            aluop;
    logic                  rtype, is_branch, use_imm, m_writes, not_equal, less_than;

    assign opcode    = dx_ir_i.r_fmt.opcode;
    assign rtype     = (opcode == OPC_RTYPE);
    assign is_branch = (opcode == OPC_BNE) || (opcode == OPC_BLT);
    assign use_imm   = (opcode == OPC_ADDI) || (opcode == OPC_LW) || (opcode == OPC_SW);
    assign src_a     = dx_ir_i.r_fmt.rs;
    assign src_b     = rtype ? dx_ir_i.r_fmt.rt : dx_ir_i.r_fmt.rd;
    assign imm_sext  = {{(XLEN-IMM_W){dx_ir_i.i_fmt.imm[IMM_W-1]}}, dx_ir_i.i_fmt.imm};

    // only R-type and addi results are ready in memory; loads stall instead
    assign m_rd     = xm_ir_o.r_fmt.rd;
    assign m_writes = ((xm_ir_o.r_fmt.opcode == OPC_RTYPE) ||
                       (xm_ir_o.r_fmt.opcode == OPC_ADDI)) && (m_rd != REG_ZERO);

    always_comb begin
        fwd_a = FWD_REG;
        fwd_b = FWD_REG;
        if (m_writes && m_rd == src_a) fwd_a = FWD_MEM;
        else if (wb_we_i && wb_rd_i != REG_ZERO && wb_rd_i == src_a) fwd_a = FWD_WB;
        if (m_writes && m_rd == src_b) fwd_b = FWD_MEM;
        else if (wb_we_i && wb_rd_i != REG_ZERO && wb_rd_i == src_b) fwd_b = FWD_WB;
    end

    always_comb begin
        case (fwd_a)
            FWD_MEM: reg_a = xm_result_o;
            FWD_WB:  reg_a = wb_data_i;
            default: reg_a = dx_a_i;
        endcase
        case (fwd_b)
            FWD_MEM: reg_b = xm_result_o;
            FWD_WB:  reg_b = wb_data_i;
            default: reg_b = dx_b_i;
        endcase
    end

    // branches put $rd on A and $rs on B
    assign op_a  = is_branch ? reg_b : reg_a;
    assign op_b  = is_branch ? reg_a : (use_imm ? imm_sext : reg_b);
    assign aluop = rtype ? dx_ir_i.r_fmt.aluop : ALU_ADD;

    alu u_alu (
        .op_a_i      (op_a),
        .op_b_i      (op_b),
        .aluop_i     (aluop),
        .shamt_i     (dx_ir_i.r_fmt.shamt),
        .result_o    (alu_result),
        .not_equal_o (not_equal),
        .less_than_o (less_than)
    );

    assign redirect_o = (opcode == OPC_J) ||
                        ((opcode == OPC_BNE) && not_equal) ||
                        ((opcode == OPC_BLT) && less_than);
    assign redirect_pc_o = (opcode == OPC_J) ?
                           {{(XLEN-TGT_W){1'b0}}, dx_ir_i.j_fmt.target} :
                           dx_pc_i + 32'd1 + imm_sext;

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            xm_ir_o <= NOP_WORD;
        end else begin
            xm_ir_o <= dx_ir_i;
        end
    end

    always_ff @(posedge clock_i) begin
        xm_result_o <= alu_result;
        xm_store_o  <= reg_b;           // forwarded $rd for sw
    end

endmodule

//--- hdl/fetch_stage.sv
/*
 * Fetch stage: program counter with hold and redirect, and the
 * fetch/decode register. A redirect squashes the fetched word.
 */
`timescale 1ns/1ps

module fetch_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic            clock_i,
    input  logic            rst_n_i,
    input  logic            stall_i,
    input  logic            redirect_i,
    input  logic [XLEN-1:0] redirect_pc_i,
    input  logic [XLEN-1:0] imem_data_i,
    output logic [XLEN-1:0] imem_addr_o,
    output logic [XLEN-1:0] fd_pc_o,
    output instr_t          fd_ir_o
);

    logic [XLEN-1:0] pc_q;

    assign imem_addr_o = pc_q;

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;      // taken branch or jump
        end else if (!stall_i) begin
            pc_q <= pc_q + 32'd1;
        end
    end

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fd_ir_o <= NOP_WORD;
        end else if (redirect_i) begin
            fd_ir_o <= NOP_WORD;        // wrong-path word
        end else if (!stall_i) begin
            fd_ir_o <= imem_data_i;
        end
    end

    always_ff @(posedge clock_i) begin
        if (!stall_i) begin
            fd_pc_o <= pc_q;
        end
    end

endmodule

//--- hdl/decode_stage.sv
/*
 * Decode stage: register-file addressing, bypass of same-cycle
 * writeback data, load-use hazard detection and the decode/execute
 * register, which takes a bubble on a stall or a redirect.
 */
`timescale 1ns/1ps

module decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                  clock_i,
    input  logic                  rst_n_i,
    input  logic [XLEN-1:0]       fd_pc_i,
    input  instr_t                fd_ir_i,
    input  logic                  redirect_i,
    input  logic [XLEN-1:0]       rf_rdata_a_i,
    input  logic [XLEN-1:0]       rf_rdata_b_i,
    input  logic                  wb_we_i,
    input  logic [REG_ADDR_W-1:0] wb_rd_i,
    input  logic [XLEN-1:0]       wb_data_i,
    output logic [REG_ADDR_W-1:0] rf_raddr_a_o,
    output logic [REG_ADDR_W-1:0] rf_raddr_b_o,
    output logic                  stall_o,
    output logic [XLEN-1:0]       dx_pc_o,
    output instr_t                dx_ir_o,
    output logic [XLEN-1:0]       dx_a_o,
    output logic [XLEN-1:0]       dx_b_o
);

    logic [OPC_W-1:0]      opcode;
    logic [REG_ADDR_W-1:0] dx_rd;
    logic [XLEN-1:0]       rdata_a, rdata_b;
    logic                  rtype, uses_a, uses_b, dx_is_lw, wb_valid;

    assign opcode = fd_ir_i.r_fmt.opcode;
    assign rtype  = (opcode == OPC_RTYPE);

    // sw, bne and blt read rd as a source on port B
    assign rf_raddr_a_o = fd_ir_i.r_fmt.rs;
    assign rf_raddr_b_o = rtype ? fd_ir_i.r_fmt.rt : fd_ir_i.r_fmt.rd;

    assign uses_a = (opcode != OPC_J);
    assign uses_b = rtype || (opcode == OPC_SW) || (opcode == OPC_BNE) || (opcode == OPC_BLT);

    // register written at this edge is not yet visible in the file
    assign wb_valid = wb_we_i && (wb_rd_i != REG_ZERO);
    assign rdata_a  = (wb_valid && wb_rd_i == rf_raddr_a_o) ? wb_data_i : rf_rdata_a_i;
    assign rdata_b  = (wb_valid && wb_rd_i == rf_raddr_b_o) ? wb_data_i : rf_rdata_b_i;

    // load in execute whose result decode needs
    assign dx_rd    = dx_ir_o.i_fmt.rd;
    assign dx_is_lw = (dx_ir_o.i_fmt.opcode == OPC_LW) && (dx_rd != REG_ZERO);
    assign stall_o  = dx_is_lw && ((uses_a && rf_raddr_a_o == dx_rd) ||
                                   (uses_b && rf_raddr_b_o == dx_rd));

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dx_ir_o <= NOP_WORD;
        end else if (stall_o || redirect_i) begin
            dx_ir_o <= NOP_WORD;        // bubble
        end else begin
            dx_ir_o <= fd_ir_i;
        end
    end

    always_ff @(posedge clock_i) begin
        dx_pc_o <= fd_pc_i;
        dx_a_o  <= rdata_a;
        dx_b_o  <= rdata_b;
    end

endmodule

//--- hdl/mem_wb_stage.sv
/*
 * Memory and writeback stages: drives data memory from the
 * execute/memory register, holds the memory/writeback register and
 * selects the register-file write, which also feeds forwarding.
 */
`timescale 1ns/1ps

module mem_wb_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                  clock_i,
    input  logic                  rst_n_i,
    input  instr_t                xm_ir_i,
    input  logic [XLEN-1:0]       xm_result_i,
    input  logic [XLEN-1:0]       xm_store_i,
    input  logic [XLEN-1:0]       dmem_rdata_i,
    output logic [XLEN-1:0]       dmem_addr_o,
    output logic [XLEN-1:0]       dmem_wdata_o,
    output logic                  dmem_wren_o,
    output logic                  rf_we_o,
    output logic [REG_ADDR_W-1:0] rf_waddr_o,
    output logic [XLEN-1:0]       rf_wdata_o,
    output logic                  wb_we_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [XLEN-1:0]       wb_data_o
);

    instr_t           mw_ir_q;
    logic [XLEN-1:0]  mw_result_q, mw_load_q;
    logic [OPC_W-1:0] w_opcode;
    logic             writes;

    assign dmem_addr_o  = xm_result_i;  // $rs + N
    assign dmem_wdata_o = xm_store_i;
    assign dmem_wren_o  = (xm_ir_i.i_fmt.opcode == OPC_SW);

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mw_ir_q <= NOP_WORD;
        end else begin
            mw_ir_q <= xm_ir_i;
        end
    end

    always_ff @(posedge clock_i) begin
        mw_result_q <= xm_result_i;
        mw_load_q   <= dmem_rdata_i;
    end

    assign w_opcode = mw_ir_q.i_fmt.opcode;
    assign writes   = ((w_opcode == OPC_RTYPE) || (w_opcode == OPC_ADDI) ||
                       (w_opcode == OPC_LW)) && (mw_ir_q.i_fmt.rd != REG_ZERO);

    assign rf_we_o    = writes;
    assign rf_waddr_o = mw_ir_q.i_fmt.rd;
    assign rf_wdata_o = (w_opcode == OPC_LW) ? mw_load_q : mw_result_q;

    // same write seen by the forwarding paths
    assign wb_we_o   = writes;
    assign wb_rd_o   = mw_ir_q.i_fmt.rd;
    assign wb_data_o = rf_wdata_o;

endmodule

//--- hdl/processor.sv
/*
 * Five-stage in-order core. Instruction memory, data memory and
 * the register file live outside and are reached through plain
 * ports with combinational reads and rising-edge writes.
 */
`timescale 1ns/1ps

module processor (
    input  logic        clock_i,
    input  logic        rst_n_i,

    output logic [31:0] imem_addr_o,     // word address
    input  logic [31:0] imem_data_i,

    output logic [31:0] dmem_addr_o,
    output logic [31:0] dmem_wdata_o,
    output logic        dmem_wren_o,
    input  logic [31:0] dmem_rdata_i,

    output logic        rf_we_o,
    output logic [4:0]  rf_waddr_o,
    output logic [4:0]  rf_raddr_a_o,
    output logic [4:0]  rf_raddr_b_o,
    output logic [31:0] rf_wdata_o,
    input  logic [31:0] rf_rdata_a_i,
    input  logic [31:0] rf_rdata_b_i
);

    logic [31:0] fd_pc, fd_ir;
    logic [31:0] dx_pc, dx_ir, dx_a, dx_b;
    logic [31:0] xm_ir, xm_result, xm_store;
    logic [31:0] redirect_pc, wb_data;
    logic [4:0]  wb_rd;
    logic        stall, redirect, wb_we;

    fetch_stage u_fetch (
        .clock_i       (clock_i),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .imem_data_i   (imem_data_i),
        .imem_addr_o   (imem_addr_o),
        .fd_pc_o       (fd_pc),
        .fd_ir_o       (fd_ir)
    );

    decode_stage u_decode (
        .clock_i      (clock_i),
        .rst_n_i      (rst_n_i),
        .fd_pc_i      (fd_pc),
        .fd_ir_i      (fd_ir),
        .redirect_i   (redirect),
        .rf_rdata_a_i (rf_rdata_a_i),
        .rf_rdata_b_i (rf_rdata_b_i),
        .wb_we_i      (wb_we),
        .wb_rd_i      (wb_rd),
        .wb_data_i    (wb_data),
        .rf_raddr_a_o (rf_raddr_a_o),
        .rf_raddr_b_o (rf_raddr_b_o),
        .stall_o      (stall),
        .dx_pc_o      (dx_pc),
        .dx_ir_o      (dx_ir),
        .dx_a_o       (dx_a),
        .dx_b_o       (dx_b)
    );

    execute_stage u_execute (
        .clock_i       (clock_i),
        .rst_n_i       (rst_n_i),
        .dx_pc_i       (dx_pc),
        .dx_ir_i       (dx_ir),
        .dx_a_i        (dx_a),
        .dx_b_i        (dx_b),
        .wb_we_i       (wb_we),
        .wb_rd_i       (wb_rd),
        .wb_data_i     (wb_data),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .xm_ir_o       (xm_ir),
        .xm_result_o   (xm_result),
        .xm_store_o    (xm_store)
    );

    mem_wb_stage u_mem_wb (
        .clock_i      (clock_i),
        .rst_n_i      (rst_n_i),
        .xm_ir_i      (xm_ir),
        .xm_result_i  (xm_result),
        .xm_store_i   (xm_store),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_wren_o  (dmem_wren_o),
        .rf_we_o      (rf_we_o),
        .rf_waddr_o   (rf_waddr_o),
        .rf_wdata_o   (rf_wdata_o),
        .wb_we_o      (wb_we),
        .wb_rd_o      (wb_rd),
        .wb_data_o    (wb_data)
    );

endmodule

//--- sim/processor_asserts.sv
/*
 * Concurrent checks on the core's register-file, data-memory and
 * fetch ports. Bound into every processor instance.
 */
`timescale 1ns/1ps

module processor_asserts (
    input logic        clock_i,
    input logic        rst_n_i,
    input logic [31:0] imem_addr_i,
    input logic        stall_i,
    input logic        redirect_i,
    input logic        dmem_wren_i,
    input logic        rf_we_i,
    input logic [4:0]  rf_waddr_i
);

    no_r0_write: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        rf_we_i |-> (rf_waddr_i != 5'd0))
        else $error("register file write to r0");

    quiet_in_reset: assert property (@(posedge clock_i)
        !rst_n_i |-> (!dmem_wren_i && !rf_we_i))
        else $error("write enable high during reset");

    quiet_after_reset: assert property (@(posedge clock_i)
        $rose(rst_n_i) |-> (!dmem_wren_i && !rf_we_i))
        else $error("write enable high in first cycle after reset");

    we_known: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        !$isunknown(rf_we_i))
        else $error("rf_we_o unknown");

    // fetch address only holds on a load-use stall or a redirect onto itself
    pc_moves: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        ($past(rst_n_i) && imem_addr_i == $past(imem_addr_i)) |->
            ($past(stall_i) || $past(redirect_i)))
        else $error("fetch address held without stall");

endmodule

bind processor processor_asserts u_asserts (
    .clock_i     (clock_i),
    .rst_n_i     (rst_n_i),
    .imem_addr_i (imem_addr_o),
    .stall_i     (stall),
    .redirect_i  (redirect),
    .dmem_wren_i (dmem_wren_o),
    .rf_we_i     (rf_we_o),
    .rf_waddr_i  (rf_waddr_o)
);

//--- sim/tb_processor.sv
/*
 * Testbench for the core: models the instruction memory, data memory
 * and register file, runs directed and random programs and compares
 * final registers and memory with an ISA-level reference model.
 */
`timescale 1ns/1ps

module tb_processor
    import isa_pkg::*;
();

    logic        clock_i, rst_n_i;
    logic [31:0] imem_addr_o, imem_data_i, dmem_addr_o, dmem_wdata_o, dmem_rdata_i;
    logic        dmem_wren_o, rf_we_o;
    logic [4:0]  rf_waddr_o, rf_raddr_a_o, rf_raddr_b_o;
    logic [31:0] rf_wdata_o, rf_rdata_a_i, rf_rdata_b_i;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] rf_mem [32];
    logic [31:0] exp_dm [256];
    logic [31:0] exp_rf [32];
    logic [31:0] lfsr;
    int          prog_len, errors, checks, run_cycles, run_limit, t;
    logic        run_active;

    processor u_dut (.*);

    always #5 clock_i = ~clock_i;

    assign imem_data_i  = imem[imem_addr_o[7:0]];
    assign dmem_rdata_i = dmem[dmem_addr_o[7:0]];
    assign rf_rdata_a_i = (rf_raddr_a_o == 5'd0) ? 32'd0 : rf_mem[rf_raddr_a_o];
    assign rf_rdata_b_i = (rf_raddr_b_o == 5'd0) ? 32'd0 : rf_mem[rf_raddr_b_o];

    always @(posedge clock_i) begin
        if (dmem_wren_o) dmem[dmem_addr_o[7:0]] <= dmem_wdata_o;
        if (rf_we_o && rf_waddr_o != 5'd0) rf_mem[rf_waddr_o] <= rf_wdata_o;
    end

    // stops a run that never reaches its halt loop
    always @(posedge clock_i) begin
        if (run_active) begin
            run_cycles <= run_cycles + 1;
            if (run_cycles >= run_limit) begin
                $display("run did not reach the halt loop within %0d cycles", run_limit);
                $display("TEST FAILED");
                $finish;
            end
        end
    end

    function automatic logic [31:0] reg_init(input int i);
        return i * 32'h9e37_79b9;           // r0 stays zero
    endfunction

    function automatic logic [31:0] mem_init(input int i);
        return (i * 32'h0001_0003) ^ 32'hc0de_0000;
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] r_op(input logic [4:0] fn, rd, rs, rt, sh);
        instr_t w;
        w = '0;
        w.r_fmt.opcode = OPC_RTYPE;
        w.r_fmt.rd     = rd;
        w.r_fmt.rs     = rs;
        w.r_fmt.rt     = rt;
        w.r_fmt.shamt  = sh;
        w.r_fmt.aluop  = fn;
        return w;
    endfunction

    function automatic logic [31:0] i_op(input logic [4:0] opc, rd, rs, input int imm);
        instr_t w;
        w = '0;
        w.i_fmt.opcode = opc;
        w.i_fmt.rd     = rd;
        w.i_fmt.rs     = rs;
        w.i_fmt.imm    = imm[IMM_W-1:0];
        return w;
    endfunction

    function automatic logic [31:0] j_op(input int tgt);
        instr_t w;
        w = '0;
        w.j_fmt.opcode = OPC_J;
        w.j_fmt.target = tgt[TGT_W-1:0];
        return w;
    endfunction

    // ISA-level model of the loaded program up to its jump to itself
    function automatic void ref_model();
        instr_t      ins;
        logic [31:0] pc, nxt, imm, a, b, d, res;
        for (int i = 0; i < 32; i++) exp_rf[i] = reg_init(i);
        for (int i = 0; i < 256; i++) exp_dm[i] = mem_init(i);
        pc = 32'd0;
        for (int step = 0; step < 4096; step++) begin
            ins = imem[pc[7:0]];
            imm = {{(XLEN-IMM_W){ins.i_fmt.imm[IMM_W-1]}}, ins.i_fmt.imm};
            a   = exp_rf[ins.r_fmt.rs];
            b   = exp_rf[ins.r_fmt.rt];
            d   = exp_rf[ins.r_fmt.rd];
            nxt = pc + 1;
            res = d;
            case (ins.r_fmt.opcode)
                OPC_RTYPE: begin
                    case (ins.r_fmt.aluop)
                        ALU_ADD: res = a + b;
                        ALU_SUB: res = a - b;
                        ALU_AND: res = a & b;
                        ALU_OR:  res = a | b;
                        ALU_SLL: res = a << ins.r_fmt.shamt;
                        ALU_SRA: res = $signed(a) >>> ins.r_fmt.shamt;
                        default: res = 32'd0;
                    endcase
                end
                OPC_ADDI: res = a + imm;
                OPC_LW:   res = exp_dm[(a + imm) & 32'hff];
                OPC_SW:   exp_dm[(a + imm) & 32'hff] = d;
                OPC_BNE:  if (d != a) nxt = pc + 1 + imm;
                OPC_BLT:  if ($signed(d) < $signed(a)) nxt = pc + 1 + imm;
                OPC_J: begin
                    if (ins.j_fmt.target == pc) return;
                    nxt = ins.j_fmt.target;
                end
                default: ;
            endcase
            if (ins.r_fmt.rd != 5'd0) exp_rf[ins.r_fmt.rd] = res;   // unchanged if no write
            pc = nxt;
        end
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Error %s: expected %h, actual %h", what, expected, actual);
        end
    endtask

    task automatic clear_program();
        for (int i = 0; i < 256; i++) imem[i] = 32'd0;
        prog_len = 0;
    endtask

    task automatic emit(input logic [31:0] w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic run_program(input string name);
        int halt_seen, cycles;
        @(posedge clock_i);
        rst_n_i <= 1'b0;
        @(posedge clock_i);
        for (int i = 0; i < 32; i++) rf_mem[i] = reg_init(i);
        for (int i = 0; i < 256; i++) dmem[i] = mem_init(i);
        ref_model();
        repeat (3) @(posedge clock_i);
        @(negedge clock_i);
        run_limit  = 3 * prog_len + 40;
        run_cycles = 0;
        run_active = 1'b1;
        halt_seen  = 0;
        cycles     = 0;
        @(posedge clock_i);
        rst_n_i <= 1'b1;
        while (halt_seen < 3) begin
            @(negedge clock_i);
            if (cycles == 0) check_value({name, " reset pc"}, 32'd0, imem_addr_o);
            if (cycles < 3) check_value({name, " dmem_wren"}, 32'd0, dmem_wren_o);
            if (cycles < 4) check_value({name, " rf_we"}, 32'd0, rf_we_o);
            if (imem_addr_o == prog_len - 1) halt_seen++;
            cycles++;
        end
        repeat (6) @(negedge clock_i);  // drain the pipeline
        run_active = 1'b0;
        for (int i = 1; i < 32; i++) begin
            check_value($sformatf("%s r%0d", name, i), exp_rf[i], rf_mem[i]);
        end
        for (int i = 0; i < 256; i++) begin
            check_value($sformatf("%s mem[%0d]", name, i), exp_dm[i], dmem[i]);
        end
    endtask

    task automatic build_alu_chain();
        clear_program();
        emit(i_op(OPC_ADDI, 1, 0, 21));
        emit(r_op(ALU_ADD, 2, 1, 1, 0));
        emit(r_op(ALU_SUB, 3, 2, 1, 0));
        emit(r_op(ALU_AND, 4, 3, 2, 0));
        emit(r_op(ALU_OR,  5, 4, 1, 0));
        emit(r_op(ALU_SLL, 6, 5, 0, 3));
        emit(r_op(ALU_SRA, 7, 6, 0, 2));
        emit(i_op(OPC_ADDI, 8, 7, -100));
        emit(r_op(ALU_SRA, 9, 8, 0, 4));
        emit(j_op(prog_len));
    endtask

    task automatic build_load_use();
        clear_program();
        emit(i_op(OPC_ADDI, 1, 0, 10));
        emit(i_op(OPC_LW, 2, 1, 4));
        emit(r_op(ALU_ADD, 3, 2, 2, 0));  // needs the load result
        emit(r_op(ALU_ADD, 4, 3, 1, 0));
        emit(i_op(OPC_SW, 4, 0, 20));
        emit(i_op(OPC_LW, 5, 0, 20));
        emit(i_op(OPC_SW, 5, 0, 21));
        emit(j_op(prog_len));
    endtask

    task automatic build_control();
        clear_program();
        emit(i_op(OPC_ADDI, 1, 0, 1));
        emit(i_op(OPC_ADDI, 2, 0, 2));
        emit(i_op(OPC_BNE, 1, 2, 2));     // taken
        emit(i_op(OPC_ADDI, 20, 0, 99));
        emit(i_op(OPC_ADDI, 21, 0, 99));
        emit(i_op(OPC_BNE, 1, 1, 1));     // not taken
        emit(i_op(OPC_ADDI, 10, 0, 7));
        emit(i_op(OPC_BLT, 1, 2, 1));     // taken
        emit(i_op(OPC_ADDI, 22, 0, 99));
        emit(i_op(OPC_BLT, 2, 1, 1));     // not taken
        emit(i_op(OPC_ADDI, 11, 0, 8));
        emit(j_op(prog_len + 3));
        emit(i_op(OPC_ADDI, 23, 0, 99));
        emit(i_op(OPC_ADDI, 24, 0, 99));
        emit(i_op(OPC_ADDI, 12, 0, 9));
        emit(j_op(prog_len));
    endtask

    task automatic build_random();
        int halt, off;
        logic [4:0] rd, rs, rt, fn;
        logic [2:0] kind;
        clear_program();
        halt = 47;
        for (int pc = 0; pc < halt; pc++) begin
            kind = rand_bits(3);
            rd   = rand_bits(4);
            rs   = rand_bits(4);
            rt   = rand_bits(4);
            case (kind)
                3'd3: emit(i_op(OPC_ADDI, rd, rs, $signed(rand_bits(8) << 24) >>> 24));
                3'd4: emit(i_op(OPC_LW, rd, rs, rand_bits(6)));
                3'd5: emit(i_op(OPC_SW, rd, rs, rand_bits(6)));
                3'd6: begin
                    off = rand_bits(3);
                    if (pc + 1 + off > halt) off = halt - pc - 1;   // forward only
                    emit(i_op(rand_bits(1) ? OPC_BLT : OPC_BNE, rd, rs, off));
                end
                3'd7: begin
                    off = pc + 1 + rand_bits(3);
                    if (off > halt) off = halt;
                    emit(j_op(off));
                end
                default: begin
                    fn = rand_bits(3);
                    if (fn > 5) fn = fn - 6;
                    emit(r_op(fn, rd, rs, rt, rand_bits(5)));
                end
            endcase
        end
        emit(j_op(halt));
    endtask

    initial begin
        clock_i    = 1'b0;
        rst_n_i    = 1'b0;
        errors     = 0;
        checks     = 0;
        run_active = 1'b0;
        run_cycles = 0;
        run_limit  = 0;
        lfsr       = 32'hf0c;
        build_alu_chain();
        run_program("alu_chain");
        build_load_use();
        run_program("load_use");
        build_control();
        run_program("control");
        for (t = 0; t < 8; t++) begin
            build_random();
            run_program($sformatf("random_%0d", t));
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
common/isa_pkg.sv
common/pipe_pkg.sv
execute/alu.sv
execute/execute_stage.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/mem_wb_stage.sv
hdl/processor.sv
sim/processor_asserts.sv
sim/tb_processor.sv

//--- Bender.yml
package:
  name: processor

sources:
  - common/isa_pkg.sv
  - common/pipe_pkg.sv
  - execute/alu.sv
  - execute/execute_stage.sv
  - hdl/fetch_stage.sv
  - hdl/decode_stage.sv
  - hdl/mem_wb_stage.sv
  - hdl/processor.sv
  - target: simulation
    files:
      - sim/processor_asserts.sv
      - sim/tb_processor.sv
